// ==== source/decode_pkg.sv ====
package decode_pkg;

    localparam int REG_ID_W = 4;  // Segment bit plus 3 index bits
    localparam int FIELD_W  = 3;  // reg, rm and opcode register field
    localparam int MOD_W    = 2;

    // Displacement kind chosen by the classifier
    localparam logic [1:0] DISP_NONE  = 2'd0;
    localparam logic [1:0] DISP_MODRM = 2'd1;  // Follows mod and rm
    localparam logic [1:0] DISP_8     = 2'd2;  // Short branch
    localparam logic [1:0] DISP_16    = 2'd3;  // Near or far branch

    // Field that an operand id is taken from
    localparam logic [1:0] SEL_NONE  = 2'd0;
    localparam logic [1:0] SEL_REG   = 2'd1;
    localparam logic [1:0] SEL_RM    = 2'd2;
    localparam logic [1:0] SEL_OPREG = 2'd3;  // Opcode bits 2..0

    // Opcode with direction and width bits
    typedef struct packed {
        logic [5:0] op;
        logic       d;  // Set when REG is the destination
        logic       w;  // Set for word operands
    } opcode_fmt_t;

    // Opcode carrying a register index in its low bits
    typedef struct packed {
        logic [4:0]         op;
        logic [FIELD_W-1:0] rg;
    } opcode_reg_t;

    typedef union packed {
        opcode_fmt_t fmt;
        opcode_reg_t reg_form;
    } opcode_u;

endpackage

// ==== source/opcode_classifier.sv ====
module opcode_classifier
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    input  decode_pkg::opcode_u                opcode,
    output logic                               cls_valid,
    output logic                               cls_need_modrm,
    output logic [1:0]                         cls_disp_kind,
    output logic                               cls_need_imm,
    output logic                               cls_imm_size,
    output logic                               cls_byte_word,
    output logic [1:0]                         cls_dst_sel,
    output logic [1:0]                         cls_src_sel,
    output logic                               cls_dst_seg,
    output logic                               cls_src_seg,
    output logic [decode_pkg::FIELD_W-1:0]     cls_op_reg,
    output logic                               cls_unknown
);

    logic       need_modrm_c;
    logic [1:0] disp_kind_c;
    logic       need_imm_c;
    logic       imm_size_c;
    logic [1:0] dst_sel_c;
    logic [1:0] src_sel_c;
    logic       dst_seg_c;
    logic       src_seg_c;
    logic       unknown_c;
    logic       byte_word_c;
    logic [1:0] rmr_dst_sel;
    logic [1:0] rmr_src_sel;

    // D bit picks which ModR/M field is the destination
    assign rmr_dst_sel = opcode.fmt.d ? decode_pkg::SEL_REG : decode_pkg::SEL_RM;
    assign rmr_src_sel = opcode.fmt.d ? decode_pkg::SEL_RM : decode_pkg::SEL_REG;

    // MOV R-IMM and the 8C..8F block carry W in bit 3
    assign byte_word_c = (opcode.reg_form.op[4:1] == 4'b1011 || opcode.fmt.op == 6'b100011)
                       ? opcode.reg_form.op[0] : opcode.fmt.w;

    always_comb
    begin
        need_modrm_c = 1'b0;
        disp_kind_c  = decode_pkg::DISP_NONE;
        need_imm_c   = 1'b0;
        imm_size_c   = 1'b0;
        dst_sel_c    = decode_pkg::SEL_NONE;
        src_sel_c    = decode_pkg::SEL_NONE;
        dst_seg_c    = 1'b0;
        src_seg_c    = 1'b0;
        unknown_c    = 1'b0;

        // First match wins
        casez (opcode)
            8'b00??_?0??,  // ALU R/M-R
            8'b1000_01??,  // TEST, XCHG R/M-R
            8'b1000_10??:  // MOV R/M-R
            begin
                need_modrm_c = 1'b1;
                disp_kind_c  = decode_pkg::DISP_MODRM;
                dst_sel_c    = rmr_dst_sel;
                src_sel_c    = rmr_src_sel;
            end

            8'b00??_?10?:  // ALU ACC-IMM
            begin
                need_imm_c = 1'b1;
                imm_size_c = opcode.fmt.w;
            end

            8'b000?_?11?,  // PUSH/POP sreg
            8'b001?_?110,  // Segment prefix
            8'b001?_?111,  // Decimal adjust
            8'b1001_100?,  // CBW/CWD
            8'b1001_1011,  // WAIT
            8'b1001_11??,  // PUSHF/POPF/SAHF/LAHF
            8'b1100_0011,  // RET
            8'b1100_1011,  // RET far
            8'b1111_0011,  // REP
            8'b1111_1010,  // CLI
            8'b1111_1100:  // CLD
            begin
                need_modrm_c = 1'b0;  // Nothing follows the opcode
            end

            8'b010?_????,  // INC/DEC/PUSH/POP reg16
            8'b1001_0???:  // NOP, XCHG ACC
            begin
                src_sel_c = decode_pkg::SEL_OPREG;
            end

            8'b0111_????,  // Jcc short
            8'b1110_1011:  // JMP short
            begin
                disp_kind_c = decode_pkg::DISP_8;
            end

            8'b1000_00??:  // ALU R/M-IMM
            begin
                need_modrm_c = 1'b1;
                disp_kind_c  = decode_pkg::DISP_MODRM;
                need_imm_c   = 1'b1;
                imm_size_c   = ~opcode.fmt.d & opcode.fmt.w;  // 83 sign-extends imm8
                dst_sel_c    = decode_pkg::SEL_RM;
            end

            8'b1000_11?0:  // MOV R/M-sreg
            begin
                need_modrm_c = 1'b1;
                disp_kind_c  = decode_pkg::DISP_MODRM;
                dst_sel_c    = rmr_dst_sel;
                src_sel_c    = rmr_src_sel;
                dst_seg_c    = opcode.fmt.d;   // Segment reg always sits in REG
                src_seg_c    = ~opcode.fmt.d;
            end

            8'b1001_1010,  // CALL far
            8'b1110_1010:  // JMP far
            begin
                disp_kind_c = decode_pkg::DISP_16;  // Offset, then segment as imm16
                need_imm_c  = 1'b1;
                imm_size_c  = 1'b1;
            end

            8'b1011_????:  // MOV R-IMM
            begin
                need_imm_c = 1'b1;
                imm_size_c = byte_word_c;
                dst_sel_c  = decode_pkg::SEL_OPREG;
            end

            8'b1100_000?:  // Shift R/M by imm8
            begin
                need_modrm_c = 1'b1;
                disp_kind_c  = decode_pkg::DISP_MODRM;
                need_imm_c   = 1'b1;
                dst_sel_c    = decode_pkg::SEL_RM;
                src_sel_c    = decode_pkg::SEL_RM;
            end

            8'b1100_011?:  // MOV IMM-to-R/M
            begin
                need_modrm_c = 1'b1;
                disp_kind_c  = decode_pkg::DISP_MODRM;
                need_imm_c   = 1'b1;
                imm_size_c   = opcode.fmt.w;
                dst_sel_c    = decode_pkg::SEL_RM;
            end

            8'b1110_1001:  // JMP near
            begin
                disp_kind_c = decode_pkg::DISP_16;
            end

            8'b1110_01??:  // IN/OUT port imm8
            begin
                need_imm_c = 1'b1;
            end

            8'b1101_00??:  // Shift R/M by 1 or CL
            begin
                need_modrm_c = 1'b1;
                disp_kind_c  = decode_pkg::DISP_MODRM;
                dst_sel_c    = decode_pkg::SEL_RM;
                src_sel_c    = decode_pkg::SEL_RM;
            end

            default:
            begin
                unknown_c = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cls_valid      <= 1'b0;
            cls_need_modrm <= 1'b0;
            cls_disp_kind  <= decode_pkg::DISP_NONE;
            cls_need_imm   <= 1'b0;
            cls_imm_size   <= 1'b0;
            cls_byte_word  <= 1'b0;
            cls_dst_sel    <= decode_pkg::SEL_NONE;
            cls_src_sel    <= decode_pkg::SEL_NONE;
            cls_dst_seg    <= 1'b0;
            cls_src_seg    <= 1'b0;
            cls_op_reg     <= '0;
            cls_unknown    <= 1'b0;
        end
        else
        begin
            cls_valid <= in_valid;
            if (in_valid)
            begin
                cls_need_modrm <= need_modrm_c;
                cls_disp_kind  <= disp_kind_c;
                cls_need_imm   <= need_imm_c;
                cls_imm_size   <= imm_size_c;
                cls_byte_word  <= byte_word_c;
                cls_dst_sel    <= dst_sel_c;
                cls_src_sel    <= src_sel_c;
                cls_dst_seg    <= dst_seg_c;
                cls_src_seg    <= src_seg_c;
                cls_op_reg     <= opcode.reg_form.rg;
                cls_unknown    <= unknown_c;
            end
        end
    end

endmodule

// ==== source/modrm_fields.sv ====
module modrm_fields
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  logic [7:0]                     modrm,
    output logic [decode_pkg::FIELD_W-1:0] mrm_reg,
    output logic [decode_pkg::FIELD_W-1:0] mrm_rm,
    output logic                           mrm_disp_need,
    output logic                           mrm_disp16
);

    logic [decode_pkg::MOD_W-1:0]   mod_f;
    logic [decode_pkg::FIELD_W-1:0] rm_f;
    logic                           direct;

    assign mod_f = modrm[7:6];
    assign rm_f  = modrm[2:0];

    // mod 00 with rm 110 is a bare 16-bit address
    assign direct = (mod_f == 2'b00) && (rm_f == 3'b110);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mrm_reg       <= '0;
            mrm_rm        <= '0;
            mrm_disp_need <= 1'b0;
            mrm_disp16    <= 1'b0;
        end
        else if (in_valid)
        begin
            mrm_reg       <= modrm[5:3];
            mrm_rm        <= rm_f;
            mrm_disp_need <= direct | (^mod_f);  // mod 01 and 10 carry disp
            mrm_disp16    <= direct | (mod_f == 2'b10);
        end
    end

endmodule

// ==== source/operand_resolver.sv ====
module operand_resolver
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cls_valid,
    input  logic                            cls_need_modrm,
    input  logic [1:0]                      cls_disp_kind,
    input  logic                            cls_need_imm,
    input  logic                            cls_imm_size,
    input  logic                            cls_byte_word,
    input  logic [1:0]                      cls_dst_sel,
    input  logic [1:0]                      cls_src_sel,
    input  logic                            cls_dst_seg,
    input  logic                            cls_src_seg,
    input  logic [decode_pkg::FIELD_W-1:0]  cls_op_reg,
    input  logic                            cls_unknown,
    input  logic [decode_pkg::FIELD_W-1:0]  mrm_reg,
    input  logic [decode_pkg::FIELD_W-1:0]  mrm_rm,
    input  logic                            mrm_disp_need,
    input  logic                            mrm_disp16,
    output logic                            out_valid,
    output logic                            need_modrm,
    output logic                            need_disp,
    output logic                            disp_size,
    output logic                            need_imm,
    output logic                            imm_size,
    output logic                            byte_word,
    output logic                            unknown,
    output logic [decode_pkg::REG_ID_W-1:0] dst,
    output logic [decode_pkg::REG_ID_W-1:0] src
);

    logic                            need_disp_c;
    logic                            disp_size_c;
    logic [decode_pkg::REG_ID_W-1:0] dst_c;
    logic [decode_pkg::REG_ID_W-1:0] src_c;

    function automatic logic [decode_pkg::REG_ID_W-1:0] build_id
    (
        input logic [1:0]                     sel,
        input logic                           seg,
        input logic [decode_pkg::FIELD_W-1:0] reg_f,
        input logic [decode_pkg::FIELD_W-1:0] rm_f,
        input logic [decode_pkg::FIELD_W-1:0] op_f
    );
        logic [decode_pkg::FIELD_W-1:0] field;

        case (sel)
            decode_pkg::SEL_REG:   field = reg_f;
            decode_pkg::SEL_RM:    field = rm_f;
            decode_pkg::SEL_OPREG: field = op_f;
            default:               field = '0;
        endcase
        return (sel == decode_pkg::SEL_NONE) ? '0 : {seg, field};
    endfunction

    always_comb
    begin
        case (cls_disp_kind)
            decode_pkg::DISP_MODRM:
            begin
                need_disp_c = mrm_disp_need;
                disp_size_c = mrm_disp16;
            end
            decode_pkg::DISP_8:
            begin
                need_disp_c = 1'b1;
                disp_size_c = 1'b0;
            end
            decode_pkg::DISP_16:
            begin
                need_disp_c = 1'b1;
                disp_size_c = 1'b1;
            end
            default:
            begin
                need_disp_c = 1'b0;
                disp_size_c = 1'b0;
            end
        endcase

        dst_c = build_id(cls_dst_sel, cls_dst_seg, mrm_reg, mrm_rm, cls_op_reg);
        src_c = build_id(cls_src_sel, cls_src_seg, mrm_reg, mrm_rm, cls_op_reg);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid  <= 1'b0;
            need_modrm <= 1'b0;
            need_disp  <= 1'b0;
            disp_size  <= 1'b0;
            need_imm   <= 1'b0;
            imm_size   <= 1'b0;
            byte_word  <= 1'b0;
            unknown    <= 1'b0;
            dst        <= '0;
            src        <= '0;
        end
        else
        begin
            out_valid <= cls_valid;
            if (cls_valid)  // Hold last result between strobes
            begin
                need_modrm <= cls_need_modrm;
                need_disp  <= need_disp_c;
                disp_size  <= disp_size_c;
                need_imm   <= cls_need_imm;
                imm_size   <= cls_imm_size;
                byte_word  <= cls_byte_word;
                unknown    <= cls_unknown;
                dst        <= dst_c;
                src        <= src_c;
            end
        end
    end

endmodule

// ==== source/instr_decoder.sv ====
module instr_decoder
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  logic [7:0]                      opcode,
    input  logic [7:0]                      modrm,
    output logic                            out_valid,
    output logic                            need_modrm,
    output logic                            need_disp,
    output logic                            disp_size,
    output logic                            need_imm,
    output logic                            imm_size,
    output logic                            byte_word,
    output logic                            unknown,
    output logic [decode_pkg::REG_ID_W-1:0] dst,
    output logic [decode_pkg::REG_ID_W-1:0] src
);

    logic                           cls_valid;
    logic                           cls_need_modrm;
    logic [1:0]                     cls_disp_kind;
    logic                           cls_need_imm;
    logic                           cls_imm_size;
    logic                           cls_byte_word;
    logic [1:0]                     cls_dst_sel;
    logic [1:0]                     cls_src_sel;
    logic                           cls_dst_seg;
    logic                           cls_src_seg;
    logic [decode_pkg::FIELD_W-1:0] cls_op_reg;
    logic                           cls_unknown;
    logic [decode_pkg::FIELD_W-1:0] mrm_reg;
    logic [decode_pkg::FIELD_W-1:0] mrm_rm;
    logic                           mrm_disp_need;
    logic                           mrm_disp16;

    // Stage 1, opcode side
    opcode_classifier i_classifier
    (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .opcode         (opcode),
        .cls_valid      (cls_valid),
        .cls_need_modrm (cls_need_modrm),
        .cls_disp_kind  (cls_disp_kind),
        .cls_need_imm   (cls_need_imm),
        .cls_imm_size   (cls_imm_size),
        .cls_byte_word  (cls_byte_word),
        .cls_dst_sel    (cls_dst_sel),
        .cls_src_sel    (cls_src_sel),
        .cls_dst_seg    (cls_dst_seg),
        .cls_src_seg    (cls_src_seg),
        .cls_op_reg     (cls_op_reg),
        .cls_unknown    (cls_unknown)
    );

    // Stage 1, ModR/M side
    modrm_fields i_modrm
    (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .modrm         (modrm),
        .mrm_reg       (mrm_reg),
        .mrm_rm        (mrm_rm),
        .mrm_disp_need (mrm_disp_need),
        .mrm_disp16    (mrm_disp16)
    );

    // Stage 2
    operand_resolver i_resolver
    (
        .clk            (clk),
        .rst            (rst),
        .cls_valid      (cls_valid),
        .cls_need_modrm (cls_need_modrm),
        .cls_disp_kind  (cls_disp_kind),
        .cls_need_imm   (cls_need_imm),
        .cls_imm_size   (cls_imm_size),
        .cls_byte_word  (cls_byte_word),
        .cls_dst_sel    (cls_dst_sel),
        .cls_src_sel    (cls_src_sel),
        .cls_dst_seg    (cls_dst_seg),
        .cls_src_seg    (cls_src_seg),
        .cls_op_reg     (cls_op_reg),
        .cls_unknown    (cls_unknown),
        .mrm_reg        (mrm_reg),
        .mrm_rm         (mrm_rm),
        .mrm_disp_need  (mrm_disp_need),
        .mrm_disp16     (mrm_disp16),
        .out_valid      (out_valid),
        .need_modrm     (need_modrm),
        .need_disp      (need_disp),
        .disp_size      (disp_size),
        .need_imm       (need_imm),
        .imm_size       (imm_size),
        .byte_word      (byte_word),
        .unknown        (unknown),
        .dst            (dst),
        .src            (src)
    );

endmodule

// ==== tests/decode_vectors.svh ====
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
    logic [7:0]                      opcode;
    logic [7:0]                      modrm;
    logic                            fill;   // Replace modrm with random data
    logic [6:0]                      flags;
    logic [decode_pkg::REG_ID_W-1:0] dst;
    logic [decode_pkg::REG_ID_W-1:0] src;
} vec_t;

vec_t vectors[$];

task automatic add_row
(
    input logic [7:0]                      op,
    input logic [7:0]                      mrm,
    input logic                            fill,
    input logic [6:0]                      flags,
    input logic [decode_pkg::REG_ID_W-1:0] dst_id,
    input logic [decode_pkg::REG_ID_W-1:0] src_id
);
    vec_t row;

    row.opcode = op;
    row.modrm  = mrm;
    row.fill   = fill;
    row.flags  = flags;
    row.dst    = dst_id;
    row.src    = src_id;
    vectors.push_back(row);
endtask

// Columns are opcode, modrm, fill, flags, dst, src
// Flags are need_modrm, need_disp disp_size, need_imm imm_size, byte_word, unknown
// ModR/M bytes used: 06 direct, 4b mod 01, 95 mod 10, d9 and e6 mod 11, 38 mod 00
task automatic load_vectors();
    add_row(8'h00, 8'hd9, 1'b0, 7'b1_00_00_0_0, 4'h1, 4'h3);  // ADD rm8, r8
    add_row(8'h02, 8'hd9, 1'b0, 7'b1_00_00_0_0, 4'h3, 4'h1);  // D set swaps sides
    add_row(8'h01, 8'h06, 1'b0, 7'b1_11_00_1_0, 4'h6, 4'h0);
    add_row(8'h03, 8'h4b, 1'b0, 7'b1_10_00_1_0, 4'h1, 4'h3);
    add_row(8'h29, 8'h95, 1'b0, 7'b1_11_00_1_0, 4'h5, 4'h2);  // SUB
    add_row(8'h3a, 8'h38, 1'b0, 7'b1_00_00_0_0, 4'h7, 4'h0);  // CMP
    add_row(8'h85, 8'he6, 1'b0, 7'b1_00_00_1_0, 4'h6, 4'h4);  // TEST
    add_row(8'h87, 8'h4b, 1'b0, 7'b1_10_00_1_0, 4'h1, 4'h3);  // XCHG
    add_row(8'h88, 8'h95, 1'b0, 7'b1_11_00_0_0, 4'h5, 4'h2);  // MOV
    add_row(8'h8b, 8'h06, 1'b0, 7'b1_11_00_1_0, 4'h0, 4'h6);
    add_row(8'h8c, 8'hd9, 1'b0, 7'b1_00_00_1_0, 4'h1, 4'hb);  // MOV rm, sreg
    add_row(8'h8c, 8'h06, 1'b0, 7'b1_11_00_1_0, 4'h6, 4'h8);
    add_row(8'h8e, 8'h4b, 1'b0, 7'b1_10_00_1_0, 4'h9, 4'h3);  // MOV sreg, rm
    add_row(8'h04, 8'h00, 1'b1, 7'b0_00_10_0_0, 4'h0, 4'h0);  // ADD AL, imm8
    add_row(8'h05, 8'h00, 1'b1, 7'b0_00_11_1_0, 4'h0, 4'h0);
    add_row(8'h3d, 8'h00, 1'b1, 7'b0_00_11_1_0, 4'h0, 4'h0);
    add_row(8'h80, 8'hd9, 1'b0, 7'b1_00_10_0_0, 4'h1, 4'h0);
    add_row(8'h81, 8'h95, 1'b0, 7'b1_11_11_1_0, 4'h5, 4'h0);  // Only 81 takes imm16
    add_row(8'h82, 8'h4b, 1'b0, 7'b1_10_10_0_0, 4'h3, 4'h0);
    add_row(8'h83, 8'h06, 1'b0, 7'b1_11_10_1_0, 4'h6, 4'h0);
    add_row(8'hb0, 8'h00, 1'b1, 7'b0_00_10_0_0, 4'h0, 4'h0);  // MOV AL, imm8
    add_row(8'hb9, 8'h00, 1'b1, 7'b0_00_11_1_0, 4'h1, 4'h0);
    add_row(8'hbf, 8'h00, 1'b1, 7'b0_00_11_1_0, 4'h7, 4'h0);
    add_row(8'hc6, 8'h38, 1'b0, 7'b1_00_10_0_0, 4'h0, 4'h0);
    add_row(8'hc7, 8'h95, 1'b0, 7'b1_11_11_1_0, 4'h5, 4'h0);
    add_row(8'he4, 8'h00, 1'b1, 7'b0_00_10_0_0, 4'h0, 4'h0);  // IN AL, port
    add_row(8'he7, 8'h00, 1'b1, 7'b0_00_10_1_0, 4'h0, 4'h0);
    add_row(8'hc0, 8'he6, 1'b0, 7'b1_00_10_0_0, 4'h6, 4'h6);  // Shift by imm8
    add_row(8'hc1, 8'h4b, 1'b0, 7'b1_10_10_1_0, 4'h3, 4'h3);
    add_row(8'hd0, 8'h95, 1'b0, 7'b1_11_00_0_0, 4'h5, 4'h5);
    add_row(8'hd3, 8'hd9, 1'b0, 7'b1_00_00_1_0, 4'h1, 4'h1);
    add_row(8'h40, 8'h00, 1'b1, 7'b0_00_00_0_0, 4'h0, 4'h0);  // INC AX
    add_row(8'h4b, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h3);
    add_row(8'h5e, 8'h00, 1'b1, 7'b0_00_00_0_0, 4'h0, 4'h6);
    add_row(8'h97, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h7);
    add_row(8'h70, 8'h00, 1'b1, 7'b0_10_00_0_0, 4'h0, 4'h0);  // Jcc short
    add_row(8'h7f, 8'h00, 1'b1, 7'b0_10_00_1_0, 4'h0, 4'h0);
    add_row(8'heb, 8'h00, 1'b1, 7'b0_10_00_1_0, 4'h0, 4'h0);
    add_row(8'he9, 8'h00, 1'b1, 7'b0_11_00_1_0, 4'h0, 4'h0);
    add_row(8'hea, 8'h00, 1'b1, 7'b0_11_11_0_0, 4'h0, 4'h0);  // Far pointer
    add_row(8'h9a, 8'h00, 1'b1, 7'b0_11_11_0_0, 4'h0, 4'h0);
    add_row(8'h06, 8'h00, 1'b1, 7'b0_00_00_0_0, 4'h0, 4'h0);  // PUSH ES
    add_row(8'h1f, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h0);
    add_row(8'h2e, 8'h00, 1'b1, 7'b0_00_00_0_0, 4'h0, 4'h0);  // CS prefix
    add_row(8'h27, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h0);
    add_row(8'h98, 8'h00, 1'b1, 7'b0_00_00_0_0, 4'h0, 4'h0);
    add_row(8'h99, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h0);
    add_row(8'h9b, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h0);
    add_row(8'h9f, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h0);
    add_row(8'hc3, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h0);
    add_row(8'hcb, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h0);
    add_row(8'hf3, 8'h00, 1'b1, 7'b0_00_00_1_0, 4'h0, 4'h0);
    add_row(8'hfa, 8'h00, 1'b1, 7'b0_00_00_0_0, 4'h0, 4'h0);
    add_row(8'h8d, 8'h00, 1'b1, 7'b0_00_00_1_1, 4'h0, 4'h0);  // LEA, W from bit 3
    add_row(8'hc4, 8'h00, 1'b1, 7'b0_00_00_0_1, 4'h0, 4'h0);
    add_row(8'ha4, 8'h00, 1'b1, 7'b0_00_00_0_1, 4'h0, 4'h0);  // MOVSB
    add_row(8'ha5, 8'h00, 1'b1, 7'b0_00_00_1_1, 4'h0, 4'h0);
    add_row(8'hc2, 8'h00, 1'b1, 7'b0_00_00_0_1, 4'h0, 4'h0);
    add_row(8'hc8, 8'h00, 1'b1, 7'b0_00_00_0_1, 4'h0, 4'h0);  // ENTER
endtask

`endif

// ==== tests/tb_instr_decoder.sv ====
module tb_instr_decoder;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_TIMEOUT = 16;  // Cycles for the pipeline to empty

    logic                            clk;
    logic                            rst;
    logic                            in_valid;
    logic [7:0]                      opcode;
    logic [7:0]                      modrm;
    logic                            out_valid;
    logic                            need_modrm;
    logic                            need_disp;
    logic                            disp_size;
    logic                            need_imm;
    logic                            imm_size;
    logic                            byte_word;
    logic                            unknown;
    logic [decode_pkg::REG_ID_W-1:0] dst;
    logic [decode_pkg::REG_ID_W-1:0] src;

    `include "decode_vectors.svh"

    vec_t       expected_q[$];
    int         due_q[$];      // Sample cycle each pending result is due
    vec_t       last_row;      // Values the outputs must hold
    logic [7:0] check_op;
    int         neg_cycle;

    instr_decoder i_dut
    (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .opcode     (opcode),
        .modrm      (modrm),
        .out_valid  (out_valid),
        .need_modrm (need_modrm),
        .need_disp  (need_disp),
        .disp_size  (disp_size),
        .need_imm   (need_imm),
        .imm_size   (imm_size),
        .byte_word  (byte_word),
        .unknown    (unknown),
        .dst        (dst),
        .src        (src)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "Decoder test stopped at %0t", $time);
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: %s is %b, expected %b (opcode %h)",
                     $time, name, actual, expected, check_op);
            stop_with_failure();
        end
    endtask

    task automatic check_reg_id
    (
        input string                           name,
        input logic [decode_pkg::REG_ID_W-1:0] actual,
        input logic [decode_pkg::REG_ID_W-1:0] expected
    );
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: %s is %h, expected %h (opcode %h)",
                     $time, name, actual, expected, check_op);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs(input vec_t row);
        check_bit("need_modrm", need_modrm, row.flags[6]);
        check_bit("need_disp", need_disp, row.flags[5]);
        check_bit("disp_size", disp_size, row.flags[4]);
        check_bit("need_imm", need_imm, row.flags[3]);
        check_bit("imm_size", imm_size, row.flags[2]);
        check_bit("byte_word", byte_word, row.flags[1]);
        check_bit("unknown", unknown, row.flags[0]);
        check_reg_id("dst", dst, row.dst);
        check_reg_id("src", src, row.src);
    endtask

    // Runs at each falling edge, where all DUT outputs are settled
    task automatic sample_outputs();
        logic due;

        due = (due_q.size() > 0) && (due_q[0] == neg_cycle);
        check_bit("out_valid", out_valid, due);
        if (due)
        begin
            void'(due_q.pop_front());
            if (expected_q.size() == 0)
            begin
                $display("Result arrived at %0t with no expected row queued", $time);
                stop_with_failure();
            end
            else
            begin
                last_row = expected_q.pop_front();
            end
        end
        check_op = last_row.opcode;
        check_outputs(last_row);  // Also covers hold between strobes
        if (in_valid === 1'b1)
        begin
            due_q.push_back(neg_cycle + 2);  // Latency is two cycles
        end
        neg_cycle++;
    endtask

    initial
    begin
        @(posedge clk);
        forever
        begin
            @(negedge clk);
            sample_outputs();
        end
    end

    task automatic drive_row(input vec_t row);
        logic [31:0] fill;

        @(posedge clk);
        fill = $urandom;
        in_valid <= 1'b1;
        opcode   <= row.opcode;
        modrm    <= row.fill ? fill[7:0] : row.modrm;
        expected_q.push_back(row);
    endtask

    task automatic drive_idle(input int cycles);
        logic [31:0] fill;

        repeat (cycles)
        begin
            @(posedge clk);
            fill = $urandom;
            in_valid <= 1'b0;
            opcode   <= fill[7:0];   // Noise that must be ignored
            modrm    <= fill[15:8];
        end
    endtask

    task automatic wait_drain();
        int waited;

        waited = 0;
        while (expected_q.size() > 0)
        begin
            if (waited == DRAIN_TIMEOUT)
            begin
                $display("Timeout: out_valid never came for %0d strobes", expected_q.size());
                stop_with_failure();
            end
            else
            begin
                @(posedge clk);
                waited++;
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h140fe165));
        rst          = 1'b1;
        in_valid     = 1'b0;
        opcode       = 8'h00;
        modrm        = 8'h00;
        last_row     = '0;  // Reset state of every output
        check_op     = 8'h00;
        neg_cycle    = 0;
        load_vectors();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        drive_idle(3);  // Nothing may come out before the first strobe

        foreach (vectors[i])  // Back to back strobes
        begin
            drive_row(vectors[i]);
        end
        drive_idle(1);
        foreach (vectors[i])  // Random gaps between strobes
        begin
            drive_idle($urandom_range(3, 0));
            drive_row(vectors[i]);
        end
        drive_idle(1);
        wait_drain();
        drive_idle(3);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+tests
source/decode_pkg.sv
source/opcode_classifier.sv
source/modrm_fields.sv
source/operand_resolver.sv
source/instr_decoder.sv
tests/tb_instr_decoder.sv
